// ==== video_pattern.f ====
src/video_timing_pkg.sv
src/pixel_pkg.sv
src/button_debounce.sv
src/xvga_timing.sv
src/checker_frame_buffer.sv
src/test_pattern_mux.sv
src/video_pattern_top.sv
testbench/video_pattern_tb.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = video_pattern_tb
FILELIST = video_pattern.f
BUILD    = obj_dir

.PHONY: sim clean

# build, run, and pass only if the pass line appears
sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee /dev/stderr | grep -x "TB PASSED" > /dev/null

clean:
	rm -rf $(BUILD)

// ==== testbench/video_pattern_tb.sv ====
////////////////////////////////////////////////////////////
// video pattern testbench
// table-driven checks of sync, border, bars, frame buffer
// and the debounced user reset, with a per-cycle monitor
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module video_pattern_tb;
   import video_timing_pkg::*;
   import pixel_pkg::*;

   localparam int DEBOUNCE     = 16;
   localparam int FRAME_CYCLES = int'(H_TOTAL) * int'(V_TOTAL);
   localparam int WAIT_LIMIT   = 2 * FRAME_CYCLES + 100;

   // one table row of pattern, position, expected pixel and sync
   typedef struct packed {
      pattern_sel_t pattern;
      h_count_t     hcount;
      v_count_t     vcount;
      rgb_t         rgb;
      video_sync_t  sync;
   } check_row_t;

   logic         vclock;
   logic         reset;
   logic         button_reset;
   pattern_sel_t pattern;
   rgb_t         vga_rgb;
   video_sync_t  vga_sync;

   check_row_t   rows [$];
   int           ticks;
   logic         ref_reset;
   logic         restarted;
   logic         timed_out;
   pattern_sel_t pat_edge;
   int           tests;
   int           errors;
   int           mon_errors;
   int           hs_low;
   int           hs_first;
   int           vs_low;
   int           vs_first;
   int           vs_last;
   int           blank_cnt;

   video_pattern_top #(.DEBOUNCE_COUNT(DEBOUNCE)) DUT (
      .vclock       (vclock),
      .reset        (reset),
      .button_reset (button_reset),
      .pattern      (pattern),
      .vga_rgb      (vga_rgb),
      .vga_sync     (vga_sync)
   );

   initial begin
      vclock = 1'b0;
      forever #2 vclock = ~vclock;
   end

   ////////////////////////////////////////////////////////////
   // reference model
   ////////////////////////////////////////////////////////////

   // output shows scan index ticks - 2
   function automatic int h_of(int t);
      return (t - 2) % int'(H_TOTAL);
   endfunction

   function automatic int v_of(int t);
      return ((t - 2) / int'(H_TOTAL)) % int'(V_TOTAL);
   endfunction

   // sync pulses and blank from the xvga rules
   function automatic video_sync_t sync_rule(int h, int v);
      video_sync_t s;
      s.hsync = !(h >= int'(H_SYNC_START) && h < int'(H_SYNC_END));
      s.vsync = !(v >= int'(V_SYNC_START) && v < int'(V_SYNC_END));
      s.blank = (h >= int'(H_ACTIVE)) || (v >= int'(V_ACTIVE));
      return s;
   endfunction

   // 64-pixel squares from bits 7:6 of column plus bits 7:6 of row
   function automatic rgb_t checker_rgb(int h, int v);
      logic [2:0] w;
      rgb_t       c;
      w = 3'((h >> 6) & 3) + 3'((v >> 6) & 3);
      c.red   = {8{w[2]}};
      c.green = {8{w[1]}};
      c.blue  = {8{w[0]}};
      return c;
   endfunction

   // clock edges since the last reset with the user reset predicted by the sequence
   always @(posedge vclock) begin
      if (reset || ref_reset) begin
         ticks <= 0;
      end else begin
         ticks <= ticks + 1;
      end
      pat_edge <= pattern;
   end

   task automatic flag_cycle(string what, logic [23:0] got, logic [23:0] want);
      mon_errors++;
      if (mon_errors <= 10) begin
         $display("MISMATCH t=%0t %s: got %h expected %h", $time, what, got, want);
      end
   endtask

   ////////////////////////////////////////////////////////////
   // per-cycle monitor
   ////////////////////////////////////////////////////////////

   always @(negedge vclock) begin : monitor
      int          h;
      int          v;
      rgb_t        want_rgb;
      video_sync_t want_sync;
      h = h_of(ticks);
      v = v_of(ticks);
      want_sync = (ticks < 2) ? SYNC_IDLE : sync_rule(h, v);
      want_rgb  = '0;
      // window lit only once all 65536 words are written
      if (ticks >= 2 + FB_DEPTH && h < FB_SIDE && v < FB_SIDE) begin
         want_rgb = checker_rgb(h, v);
      end
      if (vga_sync !== want_sync) begin
         flag_cycle("sync", {21'b0, vga_sync}, {21'b0, want_sync});
      end
      if ((ticks < 2 || pat_edge == frame || pat_edge == frame_alt) &&
          vga_rgb !== want_rgb) begin
         flag_cycle("frame pixel", vga_rgb, want_rgb);
      end
      // spans over the first frame after power-on reset
      if (ticks >= 2 && ticks < 2 + FRAME_CYCLES && !restarted) begin
         if (v == 1 && !vga_sync.hsync) begin
            if (hs_first < 0) begin
               hs_first = h;
            end
            hs_low++;
         end
         if (!vga_sync.vsync) begin
            if (vs_first < 0) begin
               vs_first = v;
            end
            vs_last = v;
            vs_low++;
         end
         if (vga_sync.blank) begin
            blank_cnt++;
         end
      end
   end

   ////////////////////////////////////////////////////////////
   // table handling
   ////////////////////////////////////////////////////////////

   task automatic add_row(pattern_sel_t p, int h, int v, logic [23:0] rgb, logic [2:0] s);
      check_row_t r;
      r.pattern = p;
      r.hcount  = h_count_t'(h);
      r.vcount  = v_count_t'(v);
      r.rgb     = rgb;
      r.sync    = s;
      rows.push_back(r);
   endtask

   task automatic report_result(string name, bit ok);
      tests++;
      if (ok) begin
         $display("%s: ok", name);
      end else begin
         errors++;
         $display("MISMATCH t=%0t %s", $time, name);
      end
   endtask

   // rows are in scan order and each waits for its own position
   task automatic run_rows(int first, int last);
      check_row_t r;
      int         waited;
      for (int i = first; i <= last && !timed_out; i++) begin
         r = rows[i];
         pattern = r.pattern;
         waited = 0;
         do begin
            @(negedge vclock);
            waited++;
         end while ((ticks < 2 || h_of(ticks) != int'(r.hcount) ||
                     v_of(ticks) != int'(r.vcount)) && waited < WAIT_LIMIT);
         tests++;
         if (waited >= WAIT_LIMIT) begin
            timed_out = 1'b1;
            errors++;
            $display("row %0d: output never reached position %0d,%0d", i, r.hcount, r.vcount);
         end else if (vga_rgb !== r.rgb || vga_sync !== r.sync) begin
            errors++;
            $display("MISMATCH t=%0t row %0d at %0d,%0d: rgb %h sync %b, expected %h %b",
                     $time, i, r.hcount, r.vcount, vga_rgb, vga_sync, r.rgb, r.sync);
         end else begin
            $display("row %0d pattern %0d at %0d,%0d: ok", i, r.pattern, r.hcount, r.vcount);
         end
      end
   endtask

   ////////////////////////////////////////////////////////////
   // sequence
   ////////////////////////////////////////////////////////////

   initial begin
      int first_b;
      int h;
      int v;
      int mark;
      void'($urandom(60));
      reset        = 1'b1;
      button_reset = 1'b0;
      pattern      = frame;
      ref_reset    = 1'b0;
      restarted    = 1'b0;
      timed_out    = 1'b0;
      tests        = 0;
      errors       = 0;
      mon_errors   = 0;
      hs_low       = 0;
      hs_first     = -1;
      vs_low       = 0;
      vs_first     = -1;
      vs_last      = -1;
      blank_cnt    = 0;

      // frame 0 while the buffer still fills its first lines
      add_row(frame, 10, 10, 24'h000000, 3'b110);
      add_row(frame_alt, 200, 40, 24'h000000, 3'b110);
      add_row(border, 0, 50, 24'hFFFFFF, 3'b110);
      add_row(border, 1023, 50, 24'hFFFFFF, 3'b110);
      add_row(border, 500, 100, 24'h000000, 3'b110);
      add_row(border, 1100, 100, 24'h000000, 3'b011);
      add_row(bars, 0, 200, 24'h000000, 3'b110);
      add_row(bars, 64, 200, 24'h0000FF, 3'b110);
      add_row(bars, 128, 200, 24'h00FF00, 3'b110);
      add_row(bars, 320, 200, 24'hFF00FF, 3'b110);
      add_row(bars, 448, 200, 24'hFFFFFF, 3'b110);
      add_row(bars, 960, 200, 24'hFFFFFF, 3'b110);
      add_row(border, 0, 767, 24'hFFFFFF, 3'b110);
      add_row(border, 512, 767, 24'hFFFFFF, 3'b110);
      add_row(border, 1023, 767, 24'hFFFFFF, 3'b110);
      add_row(border, 10, 770, 24'h000000, 3'b111);
      add_row(border, 10, 780, 24'h000000, 3'b101);
      add_row(border, 1050, 780, 24'h000000, 3'b001);
      // frame 1
      add_row(border, 0, 0, 24'hFFFFFF, 3'b110);
      add_row(border, 1023, 0, 24'hFFFFFF, 3'b110);
      add_row(border, 1024, 0, 24'h000000, 3'b111);
      add_row(frame, 300, 10, 24'h000000, 3'b110);
      // random window samples at one per band of 20 lines
      for (int i = 0; i < 8; i++) begin
         h = int'($urandom % 256);
         v = 20 + 20 * i + int'($urandom % 20);
         add_row((i % 2 == 1) ? frame_alt : frame, h, v, checker_rgb(h, v), 3'b110);
      end
      add_row(frame_alt, 255, 255, 24'hFFFF00, 3'b110);
      add_row(frame, 256, 255, 24'h000000, 3'b110);
      add_row(frame, 10, 300, 24'h000000, 3'b110);
      // after the user reset the refill runs and then completes
      first_b = rows.size();
      add_row(border, 0, 0, 24'hFFFFFF, 3'b110);
      add_row(frame, 5, 5, 24'h000000, 3'b110);
      add_row(frame_alt, 100, 30, 24'h000000, 3'b110);
      add_row(frame, 200, 60, 24'h00FFFF, 3'b110);

      repeat (8) @(negedge vclock);
      reset = 1'b0;
      run_rows(0, first_b - 1);

      if (!timed_out) begin
         report_result($sformatf("hsync low %0d cycles from %0d", hs_low, hs_first),
                       hs_low == 136 && hs_first == int'(H_SYNC_START));
         report_result($sformatf("vsync low on lines %0d to %0d", vs_first, vs_last),
                       vs_low == 6 * int'(H_TOTAL) && vs_first == 777 && vs_last == 782);
         report_result($sformatf("blank for %0d cycles per frame", blank_cnt),
                       blank_cnt == FRAME_CYCLES - 1024 * 768);

         // short pulse that the debouncer swallows
         mark = mon_errors;
         button_reset = 1'b1;
         repeat (DEBOUNCE - 6) @(negedge vclock);
         button_reset = 1'b0;
         repeat (2 * int'(H_TOTAL)) @(negedge vclock);
         report_result("short button pulse leaves timing running", mon_errors == mark);

         // button held 20 cycles with the reference reset trailing each edge by hold+2
         restarted = 1'b1;
         button_reset = 1'b1;
         repeat (DEBOUNCE + 2) @(negedge vclock);
         ref_reset = 1'b1;
         repeat (2) @(negedge vclock);
         button_reset = 1'b0;
         repeat (DEBOUNCE + 2) @(negedge vclock);
         ref_reset = 1'b0;
         run_rows(first_b, rows.size() - 1);
      end

      report_result($sformatf("per-cycle monitor with %0d mismatches", mon_errors),
                    mon_errors == 0);
      $display("tests %0d, failed %0d, monitor mismatches %0d", tests, errors, mon_errors);
      if (errors == 0 && mon_errors == 0 && !timed_out) begin
         $display("TB PASSED");
      end else begin
         $display("TB FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== src/video_pattern_top.sv ====
////////////////////////////////////////////////////////////
// video pattern top level
// xvga timing, checkerboard frame buffer and test patterns,
// restarted by a debounced user reset button
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module video_pattern_top #(
   parameter int DEBOUNCE_COUNT = 650000
) (
   input  wire                                vclock,
   input  wire                                reset,
   input  wire                                button_reset,
   input  wire pixel_pkg::pattern_sel_t       pattern,
   output pixel_pkg::rgb_t                    vga_rgb,
   output video_timing_pkg::video_sync_t      vga_sync
);
   import video_timing_pkg::*;
   import pixel_pkg::*;

   logic        user_reset;
   logic        sys_reset;
   video_pos_t  pos;
   video_sync_t sync;
   rgb_t        frame_rgb;

   // the button runs on the external reset only
   button_debounce #(.DEBOUNCE_COUNT(DEBOUNCE_COUNT)) u_debounce (
      .vclock (vclock),
      .reset  (reset),
      .noisy  (button_reset),
      .clean  (user_reset)
   );

   // either reset restarts timing and refills the frame buffer
   assign sys_reset = reset | user_reset;

   xvga_timing u_timing (
      .vclock (vclock),
      .reset  (sys_reset),
      .pos    (pos),
      .sync   (sync)
   );

   checker_frame_buffer u_frame_buffer (
      .vclock    (vclock),
      .reset     (sys_reset),
      .pos       (pos),
      .frame_rgb (frame_rgb)
   );

   test_pattern_mux u_pattern_mux (
      .pattern   (pattern),
      .vclock    (vclock),
      .reset     (sys_reset),
      .pos       (pos),
      .sync      (sync),
      .frame_rgb (frame_rgb),
      .vga_rgb   (vga_rgb),
      .vga_sync  (vga_sync)
   );

endmodule

`default_nettype wire

// ==== src/test_pattern_mux.sv ====
////////////////////////////////////////////////////////////
// test pattern select
// frame buffer, visible-area border or color bars,
// lined up with sync and registered for the output
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module test_pattern_mux (
   input  wire pixel_pkg::pattern_sel_t       pattern,
   input  wire                                vclock,
   input  wire                                reset,
   input  wire video_timing_pkg::video_pos_t  pos,
   input  wire video_timing_pkg::video_sync_t sync,
   input  wire pixel_pkg::rgb_t               frame_rgb,
   output pixel_pkg::rgb_t                    vga_rgb,
   output video_timing_pkg::video_sync_t      vga_sync
);
   import video_timing_pkg::*;
   import pixel_pkg::*;

   logic        on_edge;
   rgb_t        border_px;
   rgb_t        bars_px;
   rgb_t        border_q;
   rgb_t        bars_q;
   video_sync_t sync_q;

   // outermost row and column of the visible area, black in blank
   assign on_edge = (pos.hcount == '0) || (pos.hcount == H_ACTIVE - 1'b1) ||
                    (pos.vcount == '0) || (pos.vcount == V_ACTIVE - 1'b1);
   assign border_px = {24{on_edge && !sync.blank}};

   // eight bars of 64 pixels, repeating every 512
   assign bars_px = '{red:   {8{pos.hcount[8]}},
                      green: {8{pos.hcount[7]}},
                      blue:  {8{pos.hcount[6]}}};

   ////////////////////////////////////////////////////////////
   // stage 1 matches the frame buffer read latency
   ////////////////////////////////////////////////////////////

   always_ff @(posedge vclock) begin
      if (reset) begin
         sync_q   <= SYNC_IDLE;
         border_q <= '0;
         bars_q   <= '0;
      end else begin
         sync_q   <= sync;
         border_q <= border_px;
         bars_q   <= bars_px;
      end
   end

   // stage 2 is the output register
   always_ff @(posedge vclock) begin
      if (reset) begin
         vga_sync <= SYNC_IDLE;
         vga_rgb  <= '0;
      end else begin
         vga_sync <= sync_q;
         case (pattern)
            border:           vga_rgb <= border_q;
            bars:             vga_rgb <= bars_q;
            frame, frame_alt: vga_rgb <= frame_rgb;
            default:          vga_rgb <= '0;
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== src/checker_frame_buffer.sv ====
////////////////////////////////////////////////////////////
// checkerboard frame buffer
// fills 64K words after reset, then shows them in a
// 256x256 window at the top left of the screen
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module checker_frame_buffer (
   input  wire                               vclock,
   input  wire                               reset,
   input  wire video_timing_pkg::video_pos_t pos,
   output pixel_pkg::rgb_t                   frame_rgb
);
   import video_timing_pkg::*;
   import pixel_pkg::*;

   fb_addr_t   fill_addr;
   logic       loaded;
   logic [2:0] checker_word;
   logic [2:0] mem [FB_DEPTH];
   fb_addr_t   rd_addr;
   logic       in_window;
   logic       rd_en;
   logic [2:0] rd_word;
   logic       pixel_on;

   ////////////////////////////////////////////////////////////
   // fill
   ////////////////////////////////////////////////////////////

   // 64-pixel squares summed across column and row
   // the sum of two 2-bit fields fits in 3 bits
   assign checker_word = {1'b0, fill_addr[7:6]} + {1'b0, fill_addr[15:14]};

   always_ff @(posedge vclock) begin
      if (reset) begin
         fill_addr <= '0;
         loaded    <= 1'b0;
      end else if (!loaded) begin
         fill_addr <= fill_addr + 1'b1;
         // last word written this cycle
         if (fill_addr == fb_addr_t'(FB_DEPTH - 1)) begin
            loaded <= 1'b1;
         end
      end
   end

   // one word per cycle until the whole memory is written
   always_ff @(posedge vclock) begin
      if (!loaded) begin
         mem[fill_addr] <= checker_word;
      end
   end

   ////////////////////////////////////////////////////////////
   // readout
   ////////////////////////////////////////////////////////////

   assign in_window = (pos.hcount < FB_SIDE) && (pos.vcount < FB_SIDE);

   // vcount * 256 + hcount is exact inside the window
   assign rd_addr = {pos.vcount[7:0], pos.hcount[7:0]};
   assign rd_en   = loaded && in_window;

   always_ff @(posedge vclock) begin
      if (rd_en) begin
         rd_word <= mem[rd_addr];
      end
   end

   // marks a valid pixel in the same cycle as rd_word
   always_ff @(posedge vclock) begin
      if (reset) begin
         pixel_on <= 1'b0;
      end else begin
         pixel_on <= rd_en;
      end
   end

   // each word bit becomes a full color channel
   assign frame_rgb = pixel_on ? '{red:   {8{rd_word[2]}},
                                   green: {8{rd_word[1]}},
                                   blue:  {8{rd_word[0]}}} : '0;

   // a read needs the fill counter wrapped past the last word
   a_no_early_read: assert property (@(posedge vclock) disable iff (reset)
      rd_en |-> (fill_addr == '0));

endmodule

`default_nettype wire

// ==== src/xvga_timing.sv ====
////////////////////////////////////////////////////////////
// xvga timing generator
// pixel position counters with registered sync and blank
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module xvga_timing (
   input  wire                           vclock,
   input  wire                           reset,
   output video_timing_pkg::video_pos_t  pos,
   output video_timing_pkg::video_sync_t sync
);
   import video_timing_pkg::*;

   video_pos_t pos_next;
   logic       line_end;
   logic       frame_end;
   logic       hsync_zone;
   logic       vsync_zone;
   logic       blank_zone;

   ////////////////////////////////////////////////////////////
   // next position
   ////////////////////////////////////////////////////////////

   always_comb begin
      line_end  = (pos.hcount == H_TOTAL - 1'b1);
      frame_end = line_end && (pos.vcount == V_TOTAL - 1'b1);

      // horizontal wraps every line
      if (line_end) begin
         pos_next.hcount = '0;
      end else begin
         pos_next.hcount = pos.hcount + 1'b1;
      end

      // vertical steps only at the end of a line
      if (frame_end) begin
         pos_next.vcount = '0;
      end else if (line_end) begin
         pos_next.vcount = pos.vcount + 1'b1;
      end else begin
         pos_next.vcount = pos.vcount;
      end
   end

   ////////////////////////////////////////////////////////////
   // sync and blank
   ////////////////////////////////////////////////////////////

   // compares run on the next position so the registered
   // sync belongs to the same cycle as pos
   assign hsync_zone = (pos_next.hcount >= H_SYNC_START) &&
                       (pos_next.hcount < H_SYNC_END);
   assign vsync_zone = (pos_next.vcount >= V_SYNC_START) &&
                       (pos_next.vcount < V_SYNC_END);
   assign blank_zone = (pos_next.hcount >= H_ACTIVE) ||
                       (pos_next.vcount >= V_ACTIVE);

   always_ff @(posedge vclock) begin
      if (reset) begin
         pos  <= '0;
         sync <= SYNC_IDLE;
      end else begin
         pos        <= pos_next;
         sync.hsync <= !hsync_zone;
         sync.vsync <= !vsync_zone;
         sync.blank <= blank_zone;
      end
   end

   // the line counter wraps before it can reach the line total
   a_hcount_range: assert property (@(posedge vclock) disable iff (reset)
      pos.hcount < H_TOTAL);

endmodule

`default_nettype wire

// ==== src/button_debounce.sv ====
////////////////////////////////////////////////////////////
// button debounce
// passes a noisy level on once it has held still long enough
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module button_debounce #(
   parameter int DEBOUNCE_COUNT = 650000
) (
   input  wire  vclock,
   input  wire  reset,
   input  wire  noisy,
   output logic clean
);

   // counter wide enough to hold the full hold count
   localparam int COUNT_W = $clog2(DEBOUNCE_COUNT + 1);

   logic               sample;
   logic [COUNT_W-1:0] count;
   logic               settled;

   assign settled = (count == COUNT_W'(DEBOUNCE_COUNT));

   // any change of the input restarts the stable count
   always_ff @(posedge vclock) begin
      if (reset) begin
         sample <= noisy;
         clean  <= noisy;
         count  <= '0;
      end else if (noisy != sample) begin
         sample <= noisy;
         count  <= '0;
      end else if (settled) begin
         clean <= sample;
      end else begin
         count <= count + 1'b1;
      end
   end

   // output may only move one cycle after the hold count was reached
   a_clean_after_hold: assert property (@(posedge vclock) disable iff (reset)
      ($changed(clean) && !$past(reset)) |-> $past(settled));

endmodule

`default_nettype wire

// ==== src/pixel_pkg.sv ====
////////////////////////////////////////////////////////////
// pixel definitions
// 24-bit color, pattern select and frame buffer sizes
////////////////////////////////////////////////////////////
`default_nettype none

package pixel_pkg;

   // red in the top byte, blue in the bottom byte
   typedef struct packed {
      logic [7:0] red;
      logic [7:0] green;
      logic [7:0] blue;
   } rgb_t;

   // source select for the video output
   // frame_alt shows the frame buffer as well
   typedef enum logic [1:0] {
      frame     = 2'b00,
      border    = 2'b01,
      bars      = 2'b10,
      frame_alt = 2'b11
   } pattern_sel_t;

   // one word per pixel of the 256x256 window
   typedef logic [15:0] fb_addr_t;

   localparam int FB_SIDE  = 256;
   localparam int FB_DEPTH = 65536;

endpackage

`default_nettype wire

// ==== src/video_timing_pkg.sv ====
////////////////////////////////////////////////////////////
// xvga timing definitions
// 1024x768 at 60 Hz, counter types and the sync bundle
////////////////////////////////////////////////////////////
`default_nettype none

package video_timing_pkg;

   // counter widths cover the full line and frame totals
   typedef logic [10:0] h_count_t;
   typedef logic [9:0]  v_count_t;

   typedef struct packed {
      h_count_t hcount;
      v_count_t vcount;
   } video_pos_t;

   // hsync and vsync are active low, blank is active high
   typedef struct packed {
      logic hsync;
      logic vsync;
      logic blank;
   } video_sync_t;

   // horizontal, in pixels
   localparam h_count_t H_ACTIVE     = 11'd1024;
   localparam h_count_t H_SYNC_START = 11'd1048;
   localparam h_count_t H_SYNC_END   = 11'd1184;
   localparam h_count_t H_TOTAL      = 11'd1344;

   // vertical, in lines
   localparam v_count_t V_ACTIVE     = 10'd768;
   localparam v_count_t V_SYNC_START = 10'd777;
   localparam v_count_t V_SYNC_END   = 10'd783;
   localparam v_count_t V_TOTAL      = 10'd806;

   // state of the sync lines at position 0,0 and during reset
   localparam video_sync_t SYNC_IDLE = '{hsync: 1'b1, vsync: 1'b1, blank: 1'b0};

endpackage

`default_nettype wire
